/* all.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_pc_unit.sv
verilog/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

/* run.sh */
#!/bin/bash
# build and run the rv_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary -j 0 --assert --top-module rv_core_tb -Mdir obj_dir -f all.f

./obj_dir/Vrv_core_tb | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

/* tb/rv_core_props.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_core_props (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t pc,
  input logic          store_en,
  input logic          halt
);

  int fail_count = 0;

  // no store or halt leaks out while reset is applied
  a_quiet_in_reset: assert property (@(posedge clk) rst |-> (!store_en && !halt))
    else begin
      $error("store_en or halt high during reset");
      fail_count++;
    end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc not word aligned");
      fail_count++;
    end

  // reset loads the start address
  a_pc_after_reset: assert property (@(posedge clk) rst |=> (pc == `RV_RESET_PC))
    else begin
      $error("pc not at reset address after reset");
      fail_count++;
    end

  a_pc_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(pc))
    else begin
      $error("pc unknown after reset");
      fail_count++;
    end

endmodule

bind rv_core rv_core_props u_props (
  .clk      (clk),
  .rst      (rst),
  .pc       (pc),
  .store_en (store_en),
  .halt     (halt)
);

`default_nettype wire

/* tb/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb;
  import rv_pkg::*;

  localparam word_t NOP          = 32'h0000_0013;
  localparam word_t ECALL        = 32'h0000_0073;
  localparam word_t STORE_WORD   = 32'h0020_a023;
  localparam int    TIMEOUT      = 4000;
  localparam int    PROG_WORDS   = 512;
  localparam int    RESET_CYCLES = 10;

  logic   clk;
  logic   rst;
  word_t  insn;
  word_t  pc;
  logic   store_en;
  word_t  store_addr;
  word_t  store_data;
  logic   halt;
  word_t  prog [PROG_WORDS];
  word_t  np;
  int     n_sw;
  integer seed;
  int     errors;
  int     stores_seen;
  int     edge_count;
  word_t  model_regs [`RV_NUM_REGS];
  word_t  model_pc;
  word_t  exp_next_pc;
  logic   exp_we;
  word_t  exp_wval;
  logic   exp_st;
  word_t  exp_sa;
  word_t  exp_sd;
  logic   exp_halt;

  rv_core u_rv_core (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .store_en   (store_en),
    .store_addr (store_addr),
    .store_data (store_data),
    .halt       (halt)
  );

  always #5 clk = ~clk;

  // instruction encoders take immediates as full words
  function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                  input int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction

  function automatic word_t enc_i(input word_t imm, input int rs1, input int f3, input int rd,
                                  input int op);
    return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
  endfunction

  function automatic word_t enc_s(input word_t imm, input int rs2, input int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic word_t enc_b(input word_t imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t enc_j(input word_t imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
  endfunction

  task automatic emit(input word_t w);
    prog[np[8:0]] = w;
    np = np + 1;
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic load_const(input int rd, input word_t v);
    word_t up;
    up = (v + 32'h800) >> 12;
    emit({up[19:0], 5'(rd), 7'h37});
    emit(enc_i(v, rd, 0, rd, 'h13));
  endtask

  task automatic store_reg(input int rs2);
    emit(enc_s(word_t'($random(seed)), rs2, 1));
    n_sw = n_sw + 1;
  endtask

  task automatic build_program();
    word_t v;
    word_t imm;
    int    sh;
    np = '0;
    n_sw = 0;
    for (int k = 0; k < 4; k++) begin
      v = (k == 2) ? 32'h8000_0000 : word_t'($random(seed));
      load_const(1, v);
      v = $random(seed);
      // shift amounts 0 and 31 in the first two rounds
      sh = (k == 0) ? 0 : ((k == 1) ? 31 : ($random(seed) & 31));
      load_const(2, (v & ~32'h1f) | word_t'(sh));
      for (int f = 0; f < 8; f++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if (alt == 0 || f == 0 || f == 5) begin
            emit(enc_r(alt * 32, 2, 1, f, 5));
            store_reg(5);
          end
          if (alt == 0 || f == 5) begin
            imm = (f == 1 || f == 5) ? word_t'(sh + alt * 1024) : word_t'($random(seed));
            emit(enc_i(imm, 1, f, 6, 'h13));
            store_reg(6);
          end
        end
      end
    end
    emit({20'($random(seed)), 5'd7, 7'h37});
    store_reg(7);
    emit({20'($random(seed)), 5'd8, 7'h17});
    store_reg(8);
    emit({20'hfffff, 5'd0, 7'h37});
    store_reg(0);
    // branch operands differ only in sign and each branch skips one addi
    v = $random(seed) | 1;
    load_const(3, v);
    load_const(4, -v);
    for (int f = 0; f < 8; f++) begin
      for (int c = 0; c < 3; c++) begin
        if (f != 2 && f != 3) begin
          emit(enc_b(8, (c == 1) ? 3 : 4, (c == 0) ? 3 : 4, f));
          emit(enc_i(1, 9, 0, 9, 'h13));
          store_reg(9);
        end
      end
    end
    // forward jal, backward jal, then forward over the landing store
    emit(enc_j(8, 10));
    emit(enc_j(12, 0));
    store_reg(10);
    emit(enc_j(-8, 11));
    store_reg(11);
    emit(32'h0000_0073);
  endtask

  function automatic word_t fetch_word(input word_t addr);
    word_t idx;
    idx = addr >> 2;
    if ($isunknown(addr) || idx >= np) begin
      return NOP;
    end
    return prog[idx[8:0]];
  endfunction

  function automatic void rv_ref_step(input word_t r [32], input word_t pc_now, input word_t i,
                                      output word_t next_pc, output logic wr_en,
                                      output word_t wr_val, output logic st_en,
                                      output word_t st_addr, output word_t st_data,
                                      output logic hlt);
    word_t a;
    word_t b;
    logic  taken;
    a = r[i[19:15]];
    b = r[i[24:20]];
    next_pc = pc_now + 32'd4;
    wr_en = 1'b0;
    wr_val = '0;
    st_en = (i[6:0] == 7'h23) && (i[14:12] == 3'b010);
    st_addr = a + {{20{i[31]}}, i[31:25], i[11:7]};
    st_data = b;
    hlt = (i == 32'h0000_0073);
    taken = 1'b0;
    case (i[6:0])
      7'h37, 7'h17: begin
        wr_en = 1'b1;
        wr_val = {i[31:12], 12'b0} + ((i[5]) ? 32'd0 : pc_now);
      end
      7'h6f: begin
        wr_en = 1'b1;
        wr_val = pc_now + 32'd4;
        next_pc = pc_now + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      end
      7'h63: begin
        case (i[14:12])
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = ($signed(a) < $signed(b));
          3'b101: taken = ($signed(a) >= $signed(b));
          3'b110: taken = (a < b);
          3'b111: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = pc_now + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        end
      end
      7'h13, 7'h33: begin
        // immediate form replaces rs2 with the I immediate
        if (!i[5]) begin
          b = {{20{i[31]}}, i[31:20]};
        end
        wr_en = 1'b1;
        case (i[14:12])
          3'b000: wr_val = (i[5] && i[30]) ? a - b : a + b;
          3'b001: wr_val = a << b[4:0];
          3'b010: wr_val = {31'b0, $signed(a) < $signed(b)};
          3'b011: wr_val = {31'b0, a < b};
          3'b100: wr_val = a ^ b;
          3'b101: wr_val = i[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'b110: wr_val = a | b;
          default: wr_val = a & b;
        endcase
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  endfunction

  task automatic compare_value(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors = errors + 1;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // sw and ecall alternate during reset, then fetch follows the current pc
  always @(posedge clk) begin
    edge_count = edge_count + 1;
    #1;
    if (edge_count < RESET_CYCLES) begin
      insn <= edge_count[0] ? ECALL : STORE_WORD;
    end else begin
      insn <= fetch_word(pc);
    end
  end

  always @(negedge clk) begin
    if (rst) begin
      compare_value("pc", `RV_RESET_PC, pc);
      compare_value("store_en", 32'd0, word_t'(store_en));
      compare_value("halt", 32'd0, word_t'(halt));
    end else begin
      rv_ref_step(model_regs, model_pc, insn, exp_next_pc, exp_we, exp_wval, exp_st, exp_sa,
                  exp_sd, exp_halt);
      compare_value("pc", model_pc, pc);
      compare_value("store_en", word_t'(exp_st), word_t'(store_en));
      compare_value("halt", word_t'(exp_halt), word_t'(halt));
      if (exp_st) begin
        compare_value("store_addr", exp_sa, store_addr);
        compare_value("store_data", exp_sd, store_data);
      end
      if (store_en) begin
        stores_seen = stores_seen + 1;
      end
      if (exp_we && insn[11:7] != '0) begin
        model_regs[insn[11:7]] = exp_wval;
      end
      model_pc = exp_next_pc;
    end
  end

  initial begin
    int   cycles;
    logic halted;
    seed = 32'h9d2f_2608;
    errors = 0;
    stores_seen = 0;
    edge_count = 0;
    cycles = 0;
    halted = 1'b0;
    clk = 1'b0;
    rst = 1'b1;
    insn = STORE_WORD;
    model_pc = `RV_RESET_PC;
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    while (!halted && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles = cycles + 1;
      halted = halt;
    end
    if (!halted) begin
      errors = errors + 1;
      $display("timeout: halt never arrived within %0d cycles", TIMEOUT);
    end
    compare_value("store_count", word_t'(n_sw), word_t'(stores_seen));
    if (u_rv_core.u_props.fail_count != 0) begin
      errors = errors + u_rv_core.u_props.fail_count;
      $display("%0d assertion failures in the bound property checker",
               u_rv_core.u_props.fail_count);
    end
    $display("%0d errors, %0d of %0d stores seen", errors, stores_seen, n_sw);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount comes from the low bits of b in both R and I forms
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {31'b0, lt_signed};
      end
      alu_sltu: begin
        result = {31'b0, lt_unsigned};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = word_t'($signed(a) >>> shamt);
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_pass_b: begin
        // lui writes the U immediate unchanged
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and address width of the RV32I core
`define RV_XLEN 32

// register file geometry
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// sequential fetch advances one word
`define RV_PC_STEP 32'd4

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t pc,
  input  rv_pkg::word_t insn,
  output logic          store_en,
  output rv_pkg::word_t store_addr,
  output rv_pkg::word_t store_data,
  output logic          halt
);
  import rv_pkg::*;

  alu_op_e    alu_op;
  alu_a_sel_e alu_a_sel;
  logic       alu_b_imm;
  word_t      imm;
  logic       rd_we;
  pc_sel_e    pc_sel;
  branch_e    branch_cond;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  word_t      wb_data;
  word_t      pc_plus4;

  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign rd_addr  = insn[11:7];

  // operand and write-back selection
  assign alu_a   = (alu_a_sel == sel_pc) ? pc : rs1_data;
  assign alu_b   = alu_b_imm ? imm : rs2_data;
  assign wb_data = (pc_sel == pc_jump) ? pc_plus4 : alu_result;

  // sw address is the alu sum of rs1 and the S immediate
  assign store_addr = alu_result;
  assign store_data = rs2_data;

  rv_decoder u_decoder (
    .insn        (insn),
    .rst         (rst),
    .alu_op      (alu_op),
    .alu_a_sel   (alu_a_sel),
    .alu_b_imm   (alu_b_imm),
    .imm         (imm),
    .rd_we       (rd_we),
    .pc_sel      (pc_sel),
    .branch_cond (branch_cond),
    .store_en    (store_en),
    .halt        (halt)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (rd_addr),
    .rd_data  (wb_data),
    .we       (rd_we)
  );

  rv_alu u_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .pc_sel      (pc_sel),
    .branch_cond (branch_cond),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

endmodule

`default_nettype wire

/* verilog/rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_decoder (
  input  rv_pkg::word_t      insn,
  input  logic               rst,
  output rv_pkg::alu_op_e    alu_op,
  output rv_pkg::alu_a_sel_e alu_a_sel,
  output logic               alu_b_imm,
  output rv_pkg::word_t      imm,
  output logic               rd_we,
  output rv_pkg::pc_sel_e    pc_sel,
  output rv_pkg::branch_e    branch_cond,
  output logic               store_en,
  output logic               halt
);
  import rv_pkg::*;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates of every format, sign taken from bit 31
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21],
                  1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    alu_op      = alu_add;
    alu_a_sel   = sel_rs1;
    alu_b_imm   = 1'b0;
    imm         = imm_i;
    rd_we       = 1'b0;
    pc_sel      = pc_seq;
    branch_cond = branch_e'(funct3);
    store_en    = 1'b0;
    halt        = 1'b0;

    case (opcode)
      op_lui: begin
        alu_op    = alu_pass_b;
        alu_b_imm = 1'b1;
        imm       = imm_u;
        rd_we     = 1'b1;
      end
      op_auipc: begin
        alu_a_sel = sel_pc;
        alu_b_imm = 1'b1;
        imm       = imm_u;
        rd_we     = 1'b1;
      end
      op_jal: begin
        // link value is selected in the core, not by the alu
        imm    = imm_j;
        rd_we  = 1'b1;
        pc_sel = pc_jump;
      end
      op_branch: begin
        imm = imm_b;
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          pc_sel = pc_branch;
        end
      end
      op_store: begin
        // address is rs1 + S immediate through the adder
        imm       = imm_s;
        alu_b_imm = 1'b1;
        store_en  = (funct3 == 3'b010);
      end
      op_op_imm: begin
        alu_b_imm = 1'b1;
        rd_we     = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            alu_op = alu_sll;
            rd_we  = (funct7 == F7_BASE);
          end
          default: begin
            // srli and srai share funct3, funct7 picks the fill
            alu_op = (funct7 == F7_ALT) ? alu_sra : alu_srl;
            rd_we  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          end
        endcase
      end
      op_op: begin
        rd_we = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: alu_op = alu_add;
          {F7_ALT,  3'b000}: alu_op = alu_sub;
          {F7_BASE, 3'b001}: alu_op = alu_sll;
          {F7_BASE, 3'b010}: alu_op = alu_slt;
          {F7_BASE, 3'b011}: alu_op = alu_sltu;
          {F7_BASE, 3'b100}: alu_op = alu_xor;
          {F7_BASE, 3'b101}: alu_op = alu_srl;
          {F7_ALT,  3'b101}: alu_op = alu_sra;
          {F7_BASE, 3'b110}: alu_op = alu_or;
          {F7_BASE, 3'b111}: alu_op = alu_and;
          default: rd_we = 1'b0;
        endcase
      end
      op_system: begin
        // only ecall is recognised, everything else is a no-op
        halt = (insn[31:7] == '0);
      end
      default: begin
        // unknown opcode runs as a nop
        rd_we = 1'b0;
      end
    endcase

    // no architectural side effects while in reset
    if (rst) begin
      rd_we    = 1'b0;
      store_en = 1'b0;
      halt     = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_pc_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_pc_unit (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::pc_sel_e pc_sel,
  input  rv_pkg::branch_e branch_cond,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   pc,
  output rv_pkg::word_t   pc_plus4
);
  import rv_pkg::*;

  logic  taken;
  word_t pc_target;
  word_t pc_next;

  assign pc_plus4  = pc + `RV_PC_STEP;
  assign pc_target = pc + imm;

  // bltu and bgeu compare as unsigned
  always_comb begin
    case (branch_cond)
      br_beq:  taken = (rs1_data == rs2_data);
      br_bne:  taken = (rs1_data != rs2_data);
      br_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      br_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      br_bltu: taken = (rs1_data < rs2_data);
      br_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_sel)
      pc_branch: pc_next = taken ? pc_target : pc_plus4;
      pc_jump:   pc_next = pc_target;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // major opcodes kept by this core, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_branch = 7'b1100011,
    op_store  = 7'b0100011,
    op_op_imm = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // values match funct3 of the branch instructions
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_e;

  typedef enum logic [1:0] {
    pc_seq,
    pc_branch,
    pc_jump
  } pc_sel_e;

  typedef enum logic {
    sel_rs1,
    sel_pc
  } alu_a_sel_e;

endpackage

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  logic              we
);
  import rv_pkg::*;

  word_t regs [`RV_NUM_REGS];

  // combinational reads, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire
